/* src/saber_pkg.sv */
package saber_pkg;

    // block table geometry
    localparam int NUM_BLOCKS = 16;
    localparam int BLOCK_ID_W = 4;

    // coordinate widths, x and y in pixels, z in depth units
    localparam int POS_W   = 12;
    localparam int DEPTH_W = 14;

    // judging thresholds
    localparam int MOVE_THRESHOLD = 32;
    localparam int SABER_REACH    = 64;
    localparam int SLICE_DEPTH    = 500;
    localparam int BLOCK_SPEED    = 100;

    // scoring
    localparam int SLICE_POINTS = 10;
    localparam int SCORE_W      = 20;
    localparam int COUNT_W      = 8;

    // swing and cut direction codes
    localparam int DIR_W = 3;
    localparam logic [DIR_W-1:0] DIR_UP    = 3'd0;
    localparam logic [DIR_W-1:0] DIR_RIGHT = 3'd1;
    localparam logic [DIR_W-1:0] DIR_DOWN  = 3'd2;
    localparam logic [DIR_W-1:0] DIR_LEFT  = 3'd3;
    // only a note carries DIR_ANY, only a hand reports DIR_NONE
    localparam logic [DIR_W-1:0] DIR_ANY   = 3'd4;
    localparam logic [DIR_W-1:0] DIR_NONE  = 3'd5;

    // descriptor word, bit 7 picks the view (0 note, 1 obstacle)
    typedef union packed {
        struct packed {
            logic             kind;
            logic             color;
            logic [DIR_W-1:0] dir;
            logic [2:0]       spare;
        } note;
        struct packed {
            logic       kind;
            // half extent in units of 4 pixels
            logic [6:0] half_width;
        } obst;
    } block_word_u;

endpackage

/* src/saber_motion.sv */
`timescale 1ns/1ps

module saber_motion
    import saber_pkg::*;
(
    input  wire              clk_in,
    input  wire              rst_in,
    input  wire              frame_strobe,
    input  wire  [POS_W-1:0] tip_x,
    input  wire  [POS_W-1:0] tip_y,
    output logic [DIR_W-1:0] direction,
    output logic [POS_W-1:0] cur_x,
    output logic [POS_W-1:0] cur_y
);

    // one extra bit so the difference of two unsigned positions stays signed
    logic signed [POS_W:0] dx;
    logic signed [POS_W:0] dy;
    logic        [POS_W:0] adx;
    logic        [POS_W:0] ady;
    logic  [DIR_W-1:0]     next_dir;

    assign dx  = $signed({1'b0, tip_x}) - $signed({1'b0, cur_x});
    assign dy  = $signed({1'b0, tip_y}) - $signed({1'b0, cur_y});
    assign adx = dx[POS_W] ? -dx : dx;
    assign ady = dy[POS_W] ? -dy : dy;

    // the dominant axis wins, a tie between axes counts as no swing
    always_comb begin
        if (adx >= MOVE_THRESHOLD && adx > ady) begin
            next_dir = dx[POS_W] ? DIR_LEFT : DIR_RIGHT;
        end else if (ady >= MOVE_THRESHOLD && ady > adx) begin
            // screen y grows downward
            next_dir = dy[POS_W] ? DIR_UP : DIR_DOWN;
        end else begin
            next_dir = DIR_NONE;
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            direction <= DIR_NONE;
            cur_x     <= '0;
            cur_y     <= '0;
        end else if (frame_strobe) begin
            direction <= next_dir;
            cur_x     <= tip_x;
            cur_y     <= tip_y;
        end
    end

endmodule

/* src/block_scanner.sv */
`timescale 1ns/1ps

module block_scanner
    import saber_pkg::*;
(
    input  wire                   clk_in,
    input  wire                   rst_in,
    input  wire                   frame_strobe,
    input  wire                   load_valid,
    input  wire  [BLOCK_ID_W-1:0] load_index,
    input  wire  [POS_W-1:0]      load_x,
    input  wire  [POS_W-1:0]      load_y,
    input  wire  [DEPTH_W-1:0]    load_z,
    input  block_word_u           load_word,
    input  wire                   block_retire,
    input  wire  [BLOCK_ID_W-1:0] result_id,
    output logic                  blk_valid,
    output logic [BLOCK_ID_W-1:0] blk_id,
    output logic [POS_W-1:0]      blk_x,
    output logic [POS_W-1:0]      blk_y,
    output logic [DEPTH_W-1:0]    blk_z,
    output block_word_u           blk_word,
    output logic                  scan_busy
);

    // block table
    logic [POS_W-1:0]      mem_x    [NUM_BLOCKS];
    logic [POS_W-1:0]      mem_y    [NUM_BLOCKS];
    logic [DEPTH_W-1:0]    mem_z    [NUM_BLOCKS];
    block_word_u           mem_word [NUM_BLOCKS];
    logic [NUM_BLOCKS-1:0] live;

    // counts N presentation cycles plus two tail cycles for the last verdict
    logic [BLOCK_ID_W:0]   scan_cnt;
    logic [BLOCK_ID_W-1:0] scan_idx;
    logic                  presenting;
    logic [DEPTH_W-1:0]    next_z;

    assign scan_idx   = scan_cnt[BLOCK_ID_W-1:0];
    assign presenting = scan_busy && (scan_cnt < NUM_BLOCKS);

    // one step toward the player, stopping at the player plane
    assign next_z = (mem_z[scan_idx] > DEPTH_W'(BLOCK_SPEED))
                  ? mem_z[scan_idx] - DEPTH_W'(BLOCK_SPEED)
                  : '0;

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            scan_busy <= 1'b0;
            scan_cnt  <= '0;
            blk_valid <= 1'b0;
            live      <= '0;
        end else begin
            blk_valid <= presenting && live[scan_idx];

            if (frame_strobe) begin
                scan_busy <= 1'b1;
                scan_cnt  <= '0;
            end else if (scan_busy) begin
                // last retire lands in the cycle where the count reads N+1
                if (scan_cnt == (BLOCK_ID_W + 1)'(NUM_BLOCKS + 1)) begin
                    scan_busy <= 1'b0;
                end
                scan_cnt <= scan_cnt + 1'b1;
            end

            if (load_valid) begin
                live[load_index] <= 1'b1;
            end
            // retires arrive one cycle behind the scan and may overlap it
            if (block_retire) begin
                live[result_id] <= 1'b0;
            end
        end
    end

    // table contents and presented entry
    always_ff @(posedge clk_in) begin
        if (load_valid) begin
            mem_x[load_index]    <= load_x;
            mem_y[load_index]    <= load_y;
            mem_z[load_index]    <= load_z;
            mem_word[load_index] <= load_word;
        end
        if (presenting) begin
            if (live[scan_idx]) begin
                mem_z[scan_idx] <= next_z;
            end
            blk_id   <= scan_idx;
            blk_x    <= mem_x[scan_idx];
            blk_y    <= mem_y[scan_idx];
            blk_z    <= next_z;
            blk_word <= mem_word[scan_idx];
        end
    end

    // host side must wait for the scan to finish
    a_no_host_while_busy: assert property (
        @(posedge clk_in) disable iff (rst_in)
        scan_busy |-> !load_valid && !frame_strobe
    );

    // the judge only retires entries that were presented as live
    a_retire_live: assert property (
        @(posedge clk_in) disable iff (rst_in)
        block_retire |-> live[result_id]
    );

endmodule

/* src/state_processor.sv */
`timescale 1ns/1ps

module state_processor
    import saber_pkg::*;
(
    input  wire                   clk_in,
    input  wire                   rst_in,
    input  wire                   frame_strobe,
    input  wire  [DIR_W-1:0]      left_dir,
    input  wire  [DIR_W-1:0]      right_dir,
    input  wire  [POS_W-1:0]      left_x,
    input  wire  [POS_W-1:0]      left_y,
    input  wire  [POS_W-1:0]      right_x,
    input  wire  [POS_W-1:0]      right_y,
    input  wire  [POS_W-1:0]      head_x,
    input  wire  [POS_W-1:0]      head_y,
    input  wire                   blk_valid,
    input  wire  [BLOCK_ID_W-1:0] blk_id,
    input  wire  [POS_W-1:0]      blk_x,
    input  wire  [POS_W-1:0]      blk_y,
    input  wire  [DEPTH_W-1:0]    blk_z,
    input  block_word_u           blk_word,
    output logic                  block_sliced,
    output logic                  block_missed,
    output logic                  obstacle_hit,
    output logic                  block_retire,
    output logic [BLOCK_ID_W-1:0] result_id
);

    function automatic logic [POS_W-1:0] abs_diff(input logic [POS_W-1:0] a,
                                                   input logic [POS_W-1:0] b);
        return (a >= b) ? a - b : b - a;
    endfunction

    // hand picked by the note color, 0 is left
    logic [DIR_W-1:0] hand_dir;
    logic [POS_W-1:0] hand_x;
    logic [POS_W-1:0] hand_y;
    logic             hand_done;
    logic             left_done;
    logic             right_done;

    logic             is_note;
    logic             in_depth;
    logic             at_end;
    logic             dir_match;
    logic             tip_near;
    logic             head_near;
    logic [POS_W-1:0] obst_reach;
    logic             slice_now;
    logic             miss_now;
    logic             hit_now;

    assign hand_dir  = blk_word.note.color ? right_dir  : left_dir;
    assign hand_x    = blk_word.note.color ? right_x    : left_x;
    assign hand_y    = blk_word.note.color ? right_y    : left_y;
    assign hand_done = blk_word.note.color ? right_done : left_done;

    assign is_note  = !blk_word.note.kind;
    assign in_depth = blk_z <= SLICE_DEPTH;
    assign at_end   = blk_z == '0;

    // a still saber never cuts, not even a DIR_ANY note
    assign dir_match = hand_dir != DIR_NONE &&
                       (hand_dir == blk_word.note.dir || blk_word.note.dir == DIR_ANY);
    assign tip_near  = abs_diff(blk_x, hand_x) <= SABER_REACH &&
                       abs_diff(blk_y, hand_y) <= SABER_REACH;

    assign obst_reach = POS_W'({blk_word.obst.half_width, 2'b00});
    assign head_near  = abs_diff(blk_x, head_x) <= obst_reach &&
                        abs_diff(blk_y, head_y) <= obst_reach;

    assign slice_now = blk_valid && is_note && in_depth && tip_near && dir_match && !hand_done;
    assign miss_now  = blk_valid && is_note && !slice_now && at_end;
    // an obstacle at the player plane leaves without a hit
    assign hit_now   = blk_valid && !is_note && in_depth && !at_end && head_near;

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            block_sliced <= 1'b0;
            block_missed <= 1'b0;
            obstacle_hit <= 1'b0;
            block_retire <= 1'b0;
            left_done    <= 1'b0;
            right_done   <= 1'b0;
        end else begin
            block_sliced <= slice_now;
            block_missed <= miss_now;
            obstacle_hit <= hit_now;
            block_retire <= slice_now || miss_now || (blk_valid && !is_note && at_end);

            // one slice per hand per frame
            if (frame_strobe) begin
                left_done  <= 1'b0;
                right_done <= 1'b0;
            end else if (slice_now) begin
                if (blk_word.note.color) begin
                    right_done <= 1'b1;
                end else begin
                    left_done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (blk_valid) begin
            result_id <= blk_id;
        end
    end

    a_one_note_verdict: assert property (
        @(posedge clk_in) disable iff (rst_in)
        block_sliced |-> !block_missed
    );

endmodule

/* src/score_keeper.sv */
`timescale 1ns/1ps

module score_keeper
    import saber_pkg::*;
(
    input  wire                clk_in,
    input  wire                rst_in,
    input  wire                block_sliced,
    input  wire                block_missed,
    input  wire                obstacle_hit,
    output logic [SCORE_W-1:0] score,
    output logic [COUNT_W-1:0] combo,
    output logic [COUNT_W-1:0] miss_count
);

    // multiplier is a power of two, kept as a shift amount
    logic [1:0]         mult_shift;
    logic [SCORE_W-1:0] slice_gain;

    // multiplier from the combo before this slice is counted
    always_comb begin
        if (combo < 8) begin
            mult_shift = 2'd0;
        end else if (combo < 16) begin
            mult_shift = 2'd1;
        end else if (combo < 32) begin
            mult_shift = 2'd2;
        end else begin
            mult_shift = 2'd3;
        end
    end

    assign slice_gain = SCORE_W'(SLICE_POINTS) << mult_shift;

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            score      <= '0;
            combo      <= '0;
            miss_count <= '0;
        end else if (block_missed) begin
            combo <= '0;
            if (miss_count != '1) begin
                miss_count <= miss_count + 1'b1;
            end
        end else if (obstacle_hit) begin
            combo <= '0;
        end else if (block_sliced) begin
            score <= score + slice_gain;
            // combo holds at full scale
            if (combo != '1) begin
                combo <= combo + 1'b1;
            end
        end
    end

endmodule

/* src/slice_judge_top.sv */
`timescale 1ns/1ps

module slice_judge_top
    import saber_pkg::*;
(
    input  wire                   clk_in,
    input  wire                   rst_in,
    input  wire                   load_valid,
    input  wire  [BLOCK_ID_W-1:0] load_index,
    input  wire  [POS_W-1:0]      load_x,
    input  wire  [POS_W-1:0]      load_y,
    input  wire  [DEPTH_W-1:0]    load_z,
    input  block_word_u           load_word,
    input  wire                   frame_strobe,
    input  wire  [POS_W-1:0]      left_tip_x,
    input  wire  [POS_W-1:0]      left_tip_y,
    input  wire  [POS_W-1:0]      right_tip_x,
    input  wire  [POS_W-1:0]      right_tip_y,
    input  wire  [POS_W-1:0]      head_x,
    input  wire  [POS_W-1:0]      head_y,
    output logic                  block_sliced,
    output logic                  block_missed,
    output logic                  obstacle_hit,
    output logic [BLOCK_ID_W-1:0] result_id,
    output logic                  scan_busy,
    output logic [SCORE_W-1:0]    score,
    output logic [COUNT_W-1:0]    combo,
    output logic [COUNT_W-1:0]    miss_count
);

    // saber state, latched per frame
    logic [DIR_W-1:0]      left_dir;
    logic [DIR_W-1:0]      right_dir;
    logic [POS_W-1:0]      left_x;
    logic [POS_W-1:0]      left_y;
    logic [POS_W-1:0]      right_x;
    logic [POS_W-1:0]      right_y;

    // entry under judgment
    logic                  blk_valid;
    logic [BLOCK_ID_W-1:0] blk_id;
    logic [POS_W-1:0]      blk_x;
    logic [POS_W-1:0]      blk_y;
    logic [DEPTH_W-1:0]    blk_z;
    block_word_u           blk_word;
    logic                  block_retire;

    saber_motion u_left_saber (
        .clk_in, .rst_in, .frame_strobe,
        .tip_x(left_tip_x), .tip_y(left_tip_y),
        .direction(left_dir), .cur_x(left_x), .cur_y(left_y)
    );

    saber_motion u_right_saber (
        .clk_in, .rst_in, .frame_strobe,
        .tip_x(right_tip_x), .tip_y(right_tip_y),
        .direction(right_dir), .cur_x(right_x), .cur_y(right_y)
    );

    block_scanner u_scanner (
        .clk_in, .rst_in, .frame_strobe,
        .load_valid, .load_index, .load_x, .load_y, .load_z, .load_word,
        .block_retire, .result_id,
        .blk_valid, .blk_id, .blk_x, .blk_y, .blk_z, .blk_word,
        .scan_busy
    );

    state_processor u_processor (
        .clk_in, .rst_in, .frame_strobe,
        .left_dir, .right_dir, .left_x, .left_y, .right_x, .right_y,
        .head_x, .head_y,
        .blk_valid, .blk_id, .blk_x, .blk_y, .blk_z, .blk_word,
        .block_sliced, .block_missed, .obstacle_hit, .block_retire, .result_id
    );

    score_keeper u_score (
        .clk_in, .rst_in,
        .block_sliced, .block_missed, .obstacle_hit,
        .score, .combo, .miss_count
    );

endmodule

/* sim/tb_slice_judge.sv */
`timescale 1ns/1ps

module tb_slice_judge
    import saber_pkg::*;
();

    // frames run by all tests together, used to bound the run
    localparam int FRAME_COUNT = 62;
    localparam int CYCLE_LIMIT = FRAME_COUNT * (NUM_BLOCKS + 6) + 300;

    logic                  clk_in = 1'b0;
    logic                  rst_in;
    logic                  load_valid;
    logic [BLOCK_ID_W-1:0] load_index;
    logic [POS_W-1:0]      load_x;
    logic [POS_W-1:0]      load_y;
    logic [DEPTH_W-1:0]    load_z;
    block_word_u           load_word;
    logic                  frame_strobe;
    logic [POS_W-1:0]      left_tip_x;
    logic [POS_W-1:0]      left_tip_y;
    logic [POS_W-1:0]      right_tip_x;
    logic [POS_W-1:0]      right_tip_y;
    logic [POS_W-1:0]      head_x;
    logic [POS_W-1:0]      head_y;
    logic                  block_sliced;
    logic                  block_missed;
    logic                  obstacle_hit;
    logic [BLOCK_ID_W-1:0] result_id;
    logic                  scan_busy;
    logic [SCORE_W-1:0]    score;
    logic [COUNT_W-1:0]    combo;
    logic [COUNT_W-1:0]    miss_count;

    // verdict ids seen during the last frame, in arrival order
    logic [BLOCK_ID_W-1:0] q_sliced[$];
    logic [BLOCK_ID_W-1:0] q_missed[$];
    logic [BLOCK_ID_W-1:0] q_hit[$];

    int          checks = 0;
    int          errors = 0;
    int          test_num = 0;
    int          test_err_base = 0;
    int          cycle_count = 0;
    logic [31:0] lcg_state = 32'd7113;

    slice_judge_top UUT (.*);

    always #5 clk_in = ~clk_in;

    always @(posedge clk_in) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TB FAILED");
            $finish;
        end
    end

    task automatic check_count(input string name, input logic [COUNT_W-1:0] got,
                               input logic [COUNT_W-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: %s = %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_score(input string name, input logic [SCORE_W-1:0] got,
                               input logic [SCORE_W-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: %s = %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_id(input string name, input logic [BLOCK_ID_W-1:0] got,
                            input logic [BLOCK_ID_W-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: %s = %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_word(input string name, input block_word_u got,
                              input block_word_u exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: %s = 0x%h, expected 0x%h", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: %s = %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_verdicts(input int s, input int m, input int h);
        check_count("sliced pulses", COUNT_W'(q_sliced.size()), COUNT_W'(s));
        check_count("missed pulses", COUNT_W'(q_missed.size()), COUNT_W'(m));
        check_count("obstacle pulses", COUNT_W'(q_hit.size()), COUNT_W'(h));
    endtask

    function automatic block_word_u make_note(input logic color, input logic [DIR_W-1:0] dir);
        block_word_u w;
        w = '0;
        w.note.color = color;
        w.note.dir = dir;
        return w;
    endfunction

    function automatic block_word_u make_obstacle(input logic [6:0] half_width);
        block_word_u w;
        w = '0;
        w.obst.kind = 1'b1;
        w.obst.half_width = half_width;
        return w;
    endfunction

    // offset in -64..64, always inside the saber reach
    function automatic int next_offset();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return int'(lcg_state[30:16] % 15'd129) - 64;
    endfunction

    task automatic apply_reset();
        rst_in = 1'b1;
        frame_strobe = 1'b0;
        load_valid = 1'b0;
        repeat (4) @(posedge clk_in);
        #1;
        rst_in = 1'b0;
    endtask

    task automatic load_block(input int idx, input int x, input int y, input int z,
                              input block_word_u w);
        load_valid = 1'b1;
        load_index = BLOCK_ID_W'(idx);
        load_x = POS_W'(x);
        load_y = POS_W'(y);
        load_z = DEPTH_W'(z);
        load_word = w;
        @(posedge clk_in);
        #1;
        load_valid = 1'b0;
    endtask

    // new tips are latched at the strobe, verdicts are gathered over the whole scan
    task automatic run_frame(input int lx, input int ly, input int rx, input int ry);
        left_tip_x = POS_W'(lx);
        left_tip_y = POS_W'(ly);
        right_tip_x = POS_W'(rx);
        right_tip_y = POS_W'(ry);
        frame_strobe = 1'b1;
        @(posedge clk_in);
        #1;
        frame_strobe = 1'b0;
        q_sliced.delete();
        q_missed.delete();
        q_hit.delete();
        check_flag("scan_busy", scan_busy, 1'b1);
        for (int k = 1; k <= NUM_BLOCKS + 4; k++) begin
            @(posedge clk_in);
            #1;
            if (block_sliced) q_sliced.push_back(result_id);
            if (block_missed) q_missed.push_back(result_id);
            if (obstacle_hit) q_hit.push_back(result_id);
            // busy covers the cycle of the last verdict and no more
            check_flag("scan_busy", scan_busy, k <= NUM_BLOCKS + 1);
        end
    endtask

    task automatic start_test();
        test_num++;
        test_err_base = errors;
        apply_reset();
    endtask

    task automatic report_test(input string name);
        if (errors == test_err_base) begin
            $display("test %0d %s: ok", test_num, name);
        end else begin
            $display("test %0d %s: %0d errors", test_num, name, errors - test_err_base);
        end
    endtask

    task automatic test_reset_state();
        start_test();
        check_score("score", score, '0);
        check_count("combo", combo, '0);
        check_count("miss_count", miss_count, '0);
        check_flag("scan_busy", scan_busy, 1'b0);
        // descriptor layout, kind in bit 7
        check_word("note word", make_note(1'b1, DIR_LEFT), 8'h58);
        check_word("obstacle word", make_obstacle(7'd10), 8'h8a);
        run_frame(1000, 1000, 2000, 1000);
        check_verdicts(0, 0, 0);
        report_test("reset and empty frame");
    endtask

    task automatic test_single_slice();
        start_test();
        run_frame(960, 1000, 2000, 1000);
        load_block(3, 1000, 1000, 500, make_note(1'b0, DIR_RIGHT));
        run_frame(1000, 1000, 2000, 1000);
        check_verdicts(1, 0, 0);
        check_id("sliced id", q_sliced[0], 4'd3);
        check_score("score", score, 20'd10);
        check_count("combo", combo, 8'd1);
        // retired note stays quiet under another right swing
        run_frame(1040, 1000, 2000, 1000);
        check_verdicts(0, 0, 0);
        report_test("single slice");
    endtask

    task automatic test_no_slice_and_miss();
        start_test();
        run_frame(960, 1000, 2000, 1000);
        load_block(0, 1000, 1000, 300, make_note(1'b0, DIR_DOWN));
        load_block(1, 1065, 1000, 300, make_note(1'b0, DIR_RIGHT));
        load_block(2, 1000, 1000, 700, make_note(1'b0, DIR_RIGHT));
        load_block(3, 1000, 1000, 300, make_note(1'b1, DIR_RIGHT));
        load_block(4, 1000, 1000, 300, make_note(1'b0, DIR_RIGHT));
        run_frame(1000, 1000, 2000, 1000);
        check_verdicts(1, 0, 0);
        check_id("sliced id", q_sliced[0], 4'd4);
        run_frame(1000, 1000, 2000, 1000);
        check_verdicts(0, 0, 0);
        run_frame(1000, 1000, 2000, 1000);
        check_verdicts(0, 3, 0);
        check_id("first missed id", q_missed[0], 4'd0);
        check_id("second missed id", q_missed[1], 4'd1);
        check_id("third missed id", q_missed[2], 4'd3);
        check_count("combo", combo, '0);
        check_count("miss_count", miss_count, 8'd3);
        // the deep note needs four more frames to reach the player
        for (int f = 4; f <= 7; f++) begin
            run_frame(1000, 1000, 2000, 1000);
            check_verdicts(0, (f == 7) ? 1 : 0, 0);
            if (f == 7) check_id("late missed id", q_missed[0], 4'd2);
        end
        check_count("miss_count", miss_count, 8'd4);
        check_score("score", score, 20'd10);
        report_test("rejected slices and misses");
    endtask

    task automatic test_two_hands();
        start_test();
        run_frame(960, 1000, 2000, 960);
        load_block(5, 1000, 1000, 300, make_note(1'b0, DIR_RIGHT));
        load_block(6, 1010, 1000, 300, make_note(1'b0, DIR_RIGHT));
        load_block(7, 2000, 1000, 300, make_note(1'b1, DIR_DOWN));
        load_block(8, 2000, 1040, 500, make_note(1'b1, DIR_ANY));
        run_frame(1000, 1000, 2000, 1000);
        check_verdicts(2, 0, 0);
        check_id("left sliced id", q_sliced[0], 4'd5);
        check_id("right sliced id", q_sliced[1], 4'd7);
        check_score("score", score, 20'd20);
        run_frame(1000, 1000, 1960, 1000);
        check_verdicts(1, 0, 0);
        check_id("any-direction id", q_sliced[0], 4'd8);
        check_score("score", score, 20'd30);
        check_count("combo", combo, 8'd3);
        report_test("two hands and any direction");
    endtask

    task automatic test_obstacle();
        start_test();
        head_x = 12'd1500;
        head_y = 12'd1500;
        run_frame(960, 1000, 2000, 1000);
        load_block(2, 1000, 1000, 300, make_note(1'b0, DIR_RIGHT));
        load_block(9, 1530, 1520, 400, make_obstacle(7'd10));
        load_block(10, 1541, 1500, 400, make_obstacle(7'd10));
        for (int f = 1; f <= 5; f++) begin
            run_frame(1000, 1000, 2000, 1000);
            check_verdicts((f == 1) ? 1 : 0, 0, (f <= 3) ? 1 : 0);
            if (f <= 3) check_id("obstacle id", q_hit[0], 4'd9);
        end
        check_count("combo", combo, '0);
        check_score("score", score, 20'd10);
        report_test("obstacle hits");
    endtask

    task automatic test_combo_run();
        int                 x;
        int                 exp_combo;
        logic [SCORE_W-1:0] exp_score;
        start_test();
        exp_combo = 0;
        exp_score = '0;
        run_frame(200, 1000, 2000, 1000);
        for (int i = 0; i < 40; i++) begin
            x = 240 + 40 * i;
            load_block(i % NUM_BLOCKS, x + next_offset(), 1000 + next_offset(), 300,
                       make_note(1'b0, DIR_RIGHT));
            run_frame(x, 1000, 2000, 1000);
            // points scale with the combo held before this slice
            if (exp_combo < 8) exp_score = exp_score + 20'd10;
            else if (exp_combo < 16) exp_score = exp_score + 20'd20;
            else if (exp_combo < 32) exp_score = exp_score + 20'd40;
            else exp_score = exp_score + 20'd80;
            exp_combo++;
            check_verdicts(1, 0, 0);
            check_score("score", score, exp_score);
            check_count("combo", combo, COUNT_W'(exp_combo));
        end
        report_test("combo multiplier");
    endtask

    initial begin
        rst_in = 1'b1;
        load_valid = 1'b0;
        load_index = '0;
        load_x = '0;
        load_y = '0;
        load_z = '0;
        load_word = '0;
        frame_strobe = 1'b0;
        left_tip_x = '0;
        left_tip_y = '0;
        right_tip_x = '0;
        right_tip_y = '0;
        head_x = '0;
        head_y = '0;
        test_reset_state();
        test_single_slice();
        test_no_slice_and_miss();
        test_two_hands();
        test_obstacle();
        test_combo_run();
        $display("tests %0d, checks %0d, errors %0d", test_num, checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* src.f */
src/saber_pkg.sv
src/saber_motion.sv
src/block_scanner.sv
src/state_processor.sv
src/score_keeper.sv
src/slice_judge_top.sv
sim/tb_slice_judge.sv

/* Makefile */
# Verilator build and run of the slice judge testbench

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_slice_judge \
		-f src.f -Mdir obj_dir -o tb_slice_judge
	./obj_dir/tb_slice_judge | tee sim.log
	grep -q "TB PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
